// File: source/dcachePkg.sv
// ========================================
// Data cache shared definitions
// Word, way select and controller state
// types plus the default cache geometry
// ========================================
`default_nettype none

package dcachePkg;

	// One data or byte-address word
	typedef logic [31:0] wordT;

	// Way select, 0 is way zero and 1 is way one
	typedef logic wayT;

	// Default geometry, both must be powers of two
	localparam int DEF_SETS        = 8;
	localparam int DEF_BLOCK_WORDS = 2;

	// Controller states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		READHIT   = 3'd1,
		WRITEHIT  = 3'd2,
		WRITEBACK = 3'd3,
		FILL      = 3'd4,
		FLUSH     = 3'd5,
		STOP      = 3'd6
	} ctrlStateT;

endpackage

`default_nettype wire

// File: source/cacheAccessIf.sv
// ========================================
// Frame store access interface
// Lookup results from the store and the
// update commands from the controller
// ========================================
`timescale 1ns/1ns
`default_nettype none

interface cacheAccessIf #(
	parameter int NUM_SETS    = dcachePkg::DEF_SETS,
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
);
	import dcachePkg::*;

	// Lookup results
	logic                   hit;
	wayT                    hitWay;
	wordT                   readWord;
	wayT                    victimWay;
	logic                   victimDirty;
	wordT                   victimAddr;
	wordT [BLOCK_WORDS-1:0] victimBlock;
	wordT                   reqBase;
	logic                   anyDirty;

	// Update commands
	logic                   writeHit;
	logic                   install;
	logic                   markClean;
	logic                   touch;
	logic                   flushMode;
	wordT [BLOCK_WORDS-1:0] fillBlock;

	// Index and offset fields need power of two geometry
	if (((NUM_SETS & (NUM_SETS - 1)) != 0) || ((BLOCK_WORDS & (BLOCK_WORDS - 1)) != 0)) begin : gBadGeometry
		$error("cache geometry must be a power of two");
	end

	modport store (
		output hit, hitWay, readWord, victimWay, victimDirty, victimAddr, victimBlock,
		output reqBase, anyDirty,
		input  writeHit, install, markClean, touch, flushMode, fillBlock
	);

	modport ctrl (
		input  hit, hitWay, readWord, victimWay, victimDirty, victimAddr, victimBlock,
		input  reqBase, anyDirty,
		output writeHit, install, markClean, touch, flushMode, fillBlock
	);

endinterface

`default_nettype wire

// File: source/blockXferIf.sv
// ========================================
// Block transfer interface
// Write-back and fill requests between
// the controller and the memory port
// ========================================
`timescale 1ns/1ns
`default_nettype none

interface blockXferIf #(
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
);
	import dcachePkg::*;

	// Request side, start is a single cycle pulse
	logic                   start;
	logic                   write;
	wordT                   baseAddr;
	wordT [BLOCK_WORDS-1:0] outBlock;

	// Completion side, fillBlock valid with done
	logic                   busy;
	logic                   done;
	wordT [BLOCK_WORDS-1:0] fillBlock;

	modport port (
		input  start, write, baseAddr, outBlock,
		output busy, done, fillBlock
	);

	modport ctrl (
		output start, write, baseAddr, outBlock,
		input  busy, done, fillBlock
	);

endinterface

`default_nettype wire

// File: source/cacheStore.sv
// ========================================
// Data cache frame store
// Tag, data, valid and dirty arrays of
// both ways, hit check, victim choice and
// the dirty frame scan used by flush
// ========================================
`timescale 1ns/1ns
`default_nettype none

module cacheStore #(
	parameter int NUM_SETS    = dcachePkg::DEF_SETS,
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
) (
	input  logic            CLK,
	input  logic            nRST,
	input  dcachePkg::wordT dmemaddr,
	input  dcachePkg::wordT dmemstore,
	cacheAccessIf.store     acc
);
	import dcachePkg::*;

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int OFF_W = $clog2(BLOCK_WORDS);
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

	// Frame arrays, indexed by way then set
	logic [TAG_W-1:0]       tagArr  [2][NUM_SETS];
	wordT [BLOCK_WORDS-1:0] dataArr [2][NUM_SETS];
	logic [NUM_SETS-1:0]    validArr [2];
	logic [NUM_SETS-1:0]    dirtyArr [2];
	// Most recently used way of each set
	logic [NUM_SETS-1:0]    recUsed;

	logic [TAG_W-1:0] reqTag;
	logic [IDX_W-1:0] reqIdx;
	logic [OFF_W-1:0] reqOff;
	logic [IDX_W-1:0] setIdx;
	logic [IDX_W-1:0] flushIdx;
	wayT              flushWay;
	logic             flushFound;
	logic [1:0]       wayHit;
	wayT              hitWay;
	wayT              victimWay;

	// Request address fields
	assign reqTag      = dmemaddr[31 -: TAG_W];
	assign reqIdx      = dmemaddr[OFF_W + 2 +: IDX_W];
	assign reqOff      = dmemaddr[2 +: OFF_W];
	assign acc.reqBase = {dmemaddr[31:OFF_W + 2], {(OFF_W + 2){1'b0}}};

	// First dirty frame, way zero and low sets first
	always_comb begin
		flushFound = 1'b0;
		flushWay   = 1'b0;
		flushIdx   = '0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				if (!flushFound && dirtyArr[w][s]) begin
					flushFound = 1'b1;
					flushWay   = wayT'(w);
					flushIdx   = IDX_W'(s);
				end
			end
		end
	end

	assign acc.anyDirty = flushFound;
	assign setIdx       = acc.flushMode ? flushIdx : reqIdx;

	// Tag compare on both ways
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = validArr[w][setIdx] && (tagArr[w][setIdx] == reqTag);
		end
	end

	assign hitWay       = wayT'(!wayHit[0]);
	assign acc.hit      = |wayHit;
	assign acc.hitWay   = hitWay;
	assign acc.readWord = dataArr[hitWay][setIdx][reqOff];

	// Invalid way first, else the one not used last
	always_comb begin
		if (acc.flushMode) begin
			victimWay = flushWay;
		end else if (!validArr[0][setIdx]) begin
			victimWay = 1'b0;
		end else if (!validArr[1][setIdx]) begin
			victimWay = 1'b1;
		end else begin
			victimWay = wayT'(!recUsed[setIdx]);
		end
	end

	assign acc.victimWay   = victimWay;
	assign acc.victimDirty = dirtyArr[victimWay][setIdx];
	assign acc.victimAddr  = {tagArr[victimWay][setIdx], setIdx, {(OFF_W + 2){1'b0}}};
	assign acc.victimBlock = dataArr[victimWay][setIdx];

	// Frame status bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			validArr <= '{default: '0};
			dirtyArr <= '{default: '0};
			recUsed  <= '0;
		end else begin
			if (acc.install) begin
				validArr[victimWay][setIdx] <= 1'b1;
				dirtyArr[victimWay][setIdx] <= 1'b0;
			end
			if (acc.writeHit) begin
				dirtyArr[hitWay][setIdx] <= 1'b1;
			end
			if (acc.markClean) begin
				dirtyArr[victimWay][setIdx] <= 1'b0;
			end
			if (acc.touch) begin
				recUsed[setIdx] <= hitWay;
			end
		end
	end

	// Tags and block data
	always_ff @(posedge CLK) begin
		if (acc.install) begin
			tagArr[victimWay][setIdx]  <= reqTag;
			dataArr[victimWay][setIdx] <= acc.fillBlock;
		end else if (acc.writeHit) begin
			dataArr[hitWay][setIdx][reqOff] <= dmemstore;
		end
	end

	// Controller never writes and refills in one cycle
	aWriteInstallExcl: assert property (@(posedge CLK) disable iff (!nRST)
		!(acc.writeHit && acc.install));

	// Write hits only on a matching frame
	aWriteNeedsHit: assert property (@(posedge CLK) disable iff (!nRST)
		acc.writeHit |-> acc.hit);

endmodule

`default_nettype wire

// File: source/cacheController.sv
// ========================================
// Data cache controller
// FSM sequencing hits, victim write-back,
// block fill and the flush on halt
// ========================================
`timescale 1ns/1ns
`default_nettype none

module cacheController #(
	parameter int NUM_SETS    = dcachePkg::DEF_SETS,
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
) (
	input  logic            CLK,
	input  logic            nRST,
	input  logic            dmemREN,
	input  logic            dmemWEN,
	input  logic            halt,
	output logic            dhit,
	output logic            flushed,
	output dcachePkg::wordT dmemload,
	cacheAccessIf.ctrl      acc,
	blockXferIf.ctrl        xfer
);
	import dcachePkg::*;

	localparam int CNT_W = $clog2(2 * NUM_SETS + 1);

	ctrlStateT        state;
	ctrlStateT        nextState;
	logic             flushing;
	logic             request;
	logic [CNT_W-1:0] flushCount;

	assign request       = dmemREN || dmemWEN;
	assign acc.flushMode = flushing;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state      <= IDLE;
			flushing   <= 1'b0;
			flushCount <= '0;
		end else begin
			state <= nextState;
			// Stays set until reset, flush never ends
			if (state == IDLE && halt) begin
				flushing <= 1'b1;
			end
			if (flushing && xfer.start) begin
				flushCount <= flushCount + 1'b1;
			end
		end
	end

	always_comb begin
		nextState      = state;
		dhit           = 1'b0;
		flushed        = 1'b0;
		dmemload       = '0;
		acc.writeHit   = 1'b0;
		acc.install    = 1'b0;
		acc.markClean  = 1'b0;
		acc.touch      = 1'b0;
		acc.fillBlock  = xfer.fillBlock;
		xfer.start     = 1'b0;
		xfer.write     = 1'b0;
		xfer.baseAddr  = acc.reqBase;
		xfer.outBlock  = acc.victimBlock;

		case (state)
			IDLE: begin
				if (halt) begin
					nextState = FLUSH;
				end else if (request && acc.hit) begin
					nextState = dmemWEN ? WRITEHIT : READHIT;
				end else if (request) begin
					// Miss, dirty victim goes out first
					xfer.start = 1'b1;
					if (acc.victimDirty) begin
						xfer.write    = 1'b1;
						xfer.baseAddr = acc.victimAddr;
						nextState     = WRITEBACK;
					end else begin
						nextState = FILL;
					end
				end
			end
			READHIT: begin
				dhit      = 1'b1;
				dmemload  = acc.readWord;
				acc.touch = 1'b1;
				nextState = IDLE;
			end
			WRITEHIT: begin
				dhit         = 1'b1;
				acc.writeHit = 1'b1;
				acc.touch    = 1'b1;
				nextState    = IDLE;
			end
			WRITEBACK: begin
				if (xfer.done) begin
					acc.markClean = 1'b1;
					if (flushing) begin
						nextState = FLUSH;
					end else begin
						xfer.start = 1'b1;
						nextState  = FILL;
					end
				end
			end
			FILL: begin
				if (xfer.done) begin
					acc.install = 1'b1;
					nextState   = IDLE;
				end
			end
			FLUSH: begin
				if (acc.anyDirty) begin
					xfer.start    = 1'b1;
					xfer.write    = 1'b1;
					xfer.baseAddr = acc.victimAddr;
					nextState     = WRITEBACK;
				end else begin
					nextState = STOP;
				end
			end
			STOP: begin
				flushed = 1'b1;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	aStartWhenFree: assert property (@(posedge CLK) disable iff (!nRST)
		xfer.start |-> !xfer.busy);

	// Each frame is written back at most once during a flush
	aFlushBounded: assert property (@(posedge CLK) disable iff (!nRST)
		flushCount <= CNT_W'(2 * NUM_SETS));

endmodule

`default_nettype wire

// File: source/memPort.sv
// ========================================
// Data cache memory port
// Moves one block word by word to or
// from memory, held off by dwait
// ========================================
`timescale 1ns/1ns
`default_nettype none

module memPort #(
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
) (
	input  logic            CLK,
	input  logic            nRST,
	input  logic            dwait,
	input  dcachePkg::wordT dload,
	output logic            dREN,
	output logic            dWEN,
	output dcachePkg::wordT daddr,
	output dcachePkg::wordT dstore,
	blockXferIf.port        xfer
);
	import dcachePkg::*;

	localparam int              CNT_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BLOCK_WORDS - 1);

	logic                   active;
	logic                   writeDir;
	logic                   doneReg;
	logic [CNT_W-1:0]       wordCnt;
	logic                   taken;
	logic                   accept;
	wordT                   baseReg;
	wordT [BLOCK_WORDS-1:0] outReg;
	wordT [BLOCK_WORDS-1:0] fillReg;

	assign accept = xfer.start && !active;
	// A word moves on each edge without dwait
	assign taken  = active && !dwait;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			active   <= 1'b0;
			writeDir <= 1'b0;
			wordCnt  <= '0;
			doneReg  <= 1'b0;
		end else begin
			doneReg <= taken && (wordCnt == LAST);
			if (accept) begin
				active   <= 1'b1;
				writeDir <= xfer.write;
				wordCnt  <= '0;
			end else if (taken) begin
				if (wordCnt == LAST) begin
					active <= 1'b0;
				end else begin
					wordCnt <= wordCnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			baseReg <= xfer.baseAddr;
			outReg  <= xfer.outBlock;
		end
		if (taken && !writeDir) begin
			fillReg[wordCnt] <= dload;
		end
	end

	assign dREN   = active && !writeDir;
	assign dWEN   = active && writeDir;
	// Four byte stride from the block base
	assign daddr  = active ? (baseReg + wordT'({wordCnt, 2'b00})) : '0;
	assign dstore = (active && writeDir) ? outReg[wordCnt] : '0;

	assign xfer.busy      = active;
	assign xfer.done      = doneReg;
	assign xfer.fillBlock = fillReg;

	aOneDirection: assert property (@(posedge CLK) disable iff (!nRST)
		!(dREN && dWEN));

	// Address held through a wait
	aAddrHeld: assert property (@(posedge CLK) disable iff (!nRST)
		(dREN || dWEN) && dwait |=> $stable(daddr) && (dREN || dWEN));

endmodule

`default_nettype wire

// File: source/dcacheTop.sv
// ========================================
// Data cache top level
// Two way write-back cache joining the
// core port, frame store, controller and
// the memory port
// ========================================
`timescale 1ns/1ns
`default_nettype none

module dcacheTop #(
	parameter int NUM_SETS    = dcachePkg::DEF_SETS,
	parameter int BLOCK_WORDS = dcachePkg::DEF_BLOCK_WORDS
) (
	input  logic            CLK,
	input  logic            nRST,
	input  logic            dmemREN,
	input  logic            dmemWEN,
	input  logic            halt,
	input  dcachePkg::wordT dmemaddr,
	input  dcachePkg::wordT dmemstore,
	input  dcachePkg::wordT dload,
	input  logic            dwait,
	output logic            dhit,
	output logic            flushed,
	output logic            dREN,
	output logic            dWEN,
	output dcachePkg::wordT dmemload,
	output dcachePkg::wordT daddr,
	output dcachePkg::wordT dstore
);

	cacheAccessIf #(
		.NUM_SETS   (NUM_SETS),
		.BLOCK_WORDS(BLOCK_WORDS)
	) accBus ();

	blockXferIf #(
		.BLOCK_WORDS(BLOCK_WORDS)
	) xferBus ();

	cacheStore #(
		.NUM_SETS   (NUM_SETS),
		.BLOCK_WORDS(BLOCK_WORDS)
	) u_cacheStore (
		.CLK      (CLK),
		.nRST     (nRST),
		.dmemaddr (dmemaddr),
		.dmemstore(dmemstore),
		.acc      (accBus.store)
	);

	cacheController #(
		.NUM_SETS   (NUM_SETS),
		.BLOCK_WORDS(BLOCK_WORDS)
	) u_cacheController (
		.CLK     (CLK),
		.nRST    (nRST),
		.dmemREN (dmemREN),
		.dmemWEN (dmemWEN),
		.halt    (halt),
		.dhit    (dhit),
		.flushed (flushed),
		.dmemload(dmemload),
		.acc     (accBus.ctrl),
		.xfer    (xferBus.ctrl)
	);

	memPort #(
		.BLOCK_WORDS(BLOCK_WORDS)
	) u_memPort (
		.CLK   (CLK),
		.nRST  (nRST),
		.dwait (dwait),
		.dload (dload),
		.dREN  (dREN),
		.dWEN  (dWEN),
		.daddr (daddr),
		.dstore(dstore),
		.xfer  (xferBus.port)
	);

endmodule

`default_nettype wire

// File: bench/dcacheTb.sv
// ========================================
// Data cache testbench
// Drives core requests from the golden
// file against a word memory model with
// random wait states, checks loads, flush
// and the final memory contents
// ========================================
`timescale 1ns/1ns
`default_nettype none

module dcacheTb;
	import dcachePkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int GOLD_MAX    = 64;
	localparam int MEM_WORDS   = 1024;
	localparam int BLOCK_BYTES = DEF_BLOCK_WORDS * 4;

	logic CLK;
	logic nRST;
	logic dmemREN;
	logic dmemWEN;
	logic halt;
	wordT dmemaddr;
	wordT dmemstore;
	wordT dload;
	logic dwait;
	logic dhit;
	logic flushed;
	logic dREN;
	logic dWEN;
	wordT dmemload;
	wordT daddr;
	wordT dstore;

	// Golden entries are op, addr, data, expected
	wordT   golden [GOLD_MAX*4];
	wordT   memWords [MEM_WORDS];
	int     lineCount;
	int     checkCount;
	int     valueErrors;
	int     otherErrors;
	int     waitLeft;
	int     delay;
	integer seed;

	dcacheTop u_dcacheTop (
		.CLK      (CLK),
		.nRST     (nRST),
		.dmemREN  (dmemREN),
		.dmemWEN  (dmemWEN),
		.halt     (halt),
		.dmemaddr (dmemaddr),
		.dmemstore(dmemstore),
		.dload    (dload),
		.dwait    (dwait),
		.dhit     (dhit),
		.flushed  (flushed),
		.dREN     (dREN),
		.dWEN     (dWEN),
		.dmemload (dmemload),
		.daddr    (daddr),
		.dstore   (dstore)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Memory model, every word starts as its own byte address
	assign dload = memWords[daddr[11:2]];

	always @(posedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				memWords[i] <= wordT'(i * 4);
			end
			dwait    <= 1'b1;
			waitLeft <= 0;
		end else if ((dREN || dWEN) && dwait) begin
			if (waitLeft <= 1) begin
				dwait <= 1'b0;
			end
			waitLeft <= waitLeft - 1;
		end else begin
			// Word taken here when a request is up, then new wait for the next one
			if (dWEN) begin
				memWords[daddr[11:2]] <= dstore;
			end
			delay = $unsigned($random(seed)) % 4;
			dwait    <= (delay != 0);
			waitLeft <= delay;
		end
	end

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		checkCount++;
		if (got !== exp) begin
			valueErrors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			valueErrors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Hold one core request until dhit, load sampled mid cycle
	task automatic coreAccess(input logic isWrite, input logic expHit, input wordT addr,
		input wordT data, output wordT load);
		int   cycles;
		logic memUsed;
		cycles  = 0;
		memUsed = 1'b0;
		@(posedge CLK);
		dmemREN   <= !isWrite;
		dmemWEN   <= isWrite;
		dmemaddr  <= addr;
		dmemstore <= data;
		@(negedge CLK);
		while (!dhit) begin
			memUsed = memUsed || dREN || dWEN;
			cycles++;
			@(negedge CLK);
		end
		load = dmemload;
		// Block of the access before is still cached
		if (expHit && memUsed) begin
			otherErrors++;
			$display("Access to %h missed although its block was just used", addr);
		end
		// No memory traffic means a hit, one cycle latency
		if (!memUsed && cycles != 1) begin
			otherErrors++;
			$display("Hit on %h answered after %0d cycles instead of one", addr, cycles);
		end
		@(posedge CLK);
		dmemREN <= 1'b0;
		dmemWEN <= 1'b0;
	endtask

	task automatic haltAndFlush(input logic exp);
		@(posedge CLK);
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			@(negedge CLK);
		end
		// Must stay up until reset
		repeat (4) begin
			@(negedge CLK);
			checkFlag("flushed", flushed, exp);
		end
	endtask

	initial begin
		wordT op;
		wordT addr;
		wordT data;
		wordT exp;
		wordT load;
		wordT lastAddr;
		logic lastValid;
		logic expHit;
		seed        = 32'h24c3_e336;
		lineCount   = 0;
		checkCount  = 0;
		valueErrors = 0;
		otherErrors = 0;
		lastAddr    = '0;
		lastValid   = 1'b0;
		nRST        = 1'b0;
		dmemREN     = 1'b0;
		dmemWEN     = 1'b0;
		halt        = 1'b0;
		dmemaddr    = '0;
		dmemstore   = '0;
		dwait       = 1'b1;
		for (int i = 0; i < GOLD_MAX * 4; i++) begin
			golden[i] = '0;
		end
		$readmemh("bench/dcacheGolden.txt", golden);
		while (lineCount < GOLD_MAX && golden[lineCount*4] != 0) begin
			lineCount++;
		end
		if (lineCount == 0) begin
			otherErrors++;
			$display("Golden file holds no entries");
		end
		repeat (3) @(posedge CLK);
		nRST <= 1'b1;
		for (int n = 0; n < lineCount; n++) begin
			op   = golden[n*4];
			addr = golden[n*4 + 1];
			data = golden[n*4 + 2];
			exp  = golden[n*4 + 3];
			case (op)
				1, 2: begin
					expHit = lastValid && (addr / BLOCK_BYTES == lastAddr / BLOCK_BYTES);
					coreAccess(op == 2, expHit, addr, data, load);
					if (op == 1) begin
						checkWord($sformatf("dmemload[%h]", addr), load, exp);
					end
					lastAddr  = addr;
					lastValid = 1'b1;
				end
				3: haltAndFlush(exp[0]);
				4: checkWord($sformatf("memWords[%h]", addr), memWords[addr[11:2]], exp);
				default: begin
					otherErrors++;
					$display("Unknown golden op code %0h on line %0d", op, n);
				end
			endcase
		end
		repeat (2) @(posedge CLK);
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checkCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog, 200 cycles for each golden line
	initial begin
		ctrlStateT stuckState;
		wait (lineCount > 0);
		#(lineCount * 200 * CLK_PERIOD);
		stuckState = u_dcacheTop.u_cacheController.state;
		$display("Timeout after %0d golden lines, controller stuck in %s",
			lineCount, stuckState.name());
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/dcacheGolden.txt
// Columns: op addr data expected, all hex
// op 1 read, 2 write, 3 halt (expected flushed), 4 memory word check, 0 ends the list
// Read of untouched memory, then the same word again as a hit
1 00000010 00000000 00000010
1 00000010 00000000 00000010
// Write and read back, the neighbor word keeps its address value
2 00000020 a5a50020 00000000
1 00000020 00000000 a5a50020
1 00000024 00000000 00000024
// Three tags in set 1, way one is not recently used at the third
2 00000008 11110008 00000000
2 0000004c 2222004c 00000000
1 00000008 00000000 11110008
1 00000088 00000000 00000088
// Dirty block of way one written back, way zero still only cached
4 00000048 00000000 00000048
4 0000004c 00000000 2222004c
4 00000008 00000000 00000008
// Round trips through memory after evictions
1 0000004c 00000000 2222004c
4 00000008 00000000 11110008
1 00000008 00000000 11110008
2 0000008c 3333008c 00000000
1 0000008c 00000000 3333008c
2 00000100 44440100 00000000
2 000001fc 555501fc 00000000
1 00000104 00000000 00000104
// Halt, flush every dirty frame
3 00000000 00000000 00000001
// Final memory words
4 00000020 00000000 a5a50020
4 00000024 00000000 00000024
4 00000008 00000000 11110008
4 0000000c 00000000 0000000c
4 00000048 00000000 00000048
4 0000004c 00000000 2222004c
4 00000088 00000000 00000088
4 0000008c 00000000 3333008c
4 00000100 00000000 44440100
4 00000104 00000000 00000104
4 000001f8 00000000 000001f8
4 000001fc 00000000 555501fc
4 00000010 00000000 00000010
0 00000000 00000000 00000000

// File: dcacheTop.f
source/dcachePkg.sv
source/cacheAccessIf.sv
source/blockXferIf.sv
source/cacheStore.sv
source/cacheController.sv
source/memPort.sv
source/dcacheTop.sv
bench/dcacheTb.sv

// File: Makefile
# Verilator flow for the data cache

TB  = dcacheTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f dcacheTop.f --top-module dcacheTop
	verilator --lint-only --timing --assert -f dcacheTop.f --top-module $(TB)

sim:
	verilator --binary --timing --assert -f dcacheTop.f --top-module $(TB) \
		-Mdir obj_dir -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
